//--- sim/vec_unit_input.txt
# instr(hex) scalar(hex) tag drop : instr = op[31:28] imm[27:12] rsvd[11:10] addr[9:0]
# tag: 0 random operands, 1 small operands, 2 B all ones; drop 1: strobe sent while busy
00005010 00000010 0 0
1FFFF020 7FFFFFFF 0 0
280013FF FFFF1234 0 0
31234155 A5A5A5A5 0 0
80000040 00000000 0 0
90000100 00000000 0 0
A0000200 00000000 1 0
B0000080 00000003 1 0
8FFFFC40 00000000 2 0
800003F8 00000000 2 0
B00003FA FFFFFFFF 0 0
00007123 00000001 0 1
10010301 00001000 0 0
A00003FF 00000000 1 0
90000000 00000000 0 1
3FFFF000 00000000 0 0
900002AA 00000000 1 0
2000F00F 12345678 0 0
30000011 00000000 0 1
B0000123 00010001 0 0

//--- filelist.f
+incdir+src
src/vec_isa_pkg.sv
src/vec_pipe_pkg.sv
src/vec_decode.sv
src/vec_execute.sv
src/vec_write_stage.sv
src/vec_unit_top.sv
sim/vec_unit_props.sv
sim/vec_unit_checker.sv
sim/vec_unit_tb.sv

//--- Bender.yml
package:
  name: vec_unit

sources:
  # RTL
  - include_dirs:
      - src
    files:
      - src/vec_isa_pkg.sv
      - src/vec_pipe_pkg.sv
      - src/vec_decode.sv
      - src/vec_execute.sv
      - src/vec_write_stage.sv
      - src/vec_unit_top.sv

  # Simulation only
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/vec_unit_props.sv
      - sim/vec_unit_checker.sv
      - sim/vec_unit_tb.sv

//--- sim/vec_unit_tb.sv
`timescale 1ns/10ps

`include "vec_settings.svh"

module vec_unit_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;

    // One stimulus record: instruction, scalar, operand fill tag, drop flag
    typedef struct packed {
        vec_isa_pkg::instr_u   instr;
        logic [`VEC_WIDTH-1:0] scalar;
        logic [3:0]            tag;
        logic                  drop;
    } record_t;

    logic                     clk;
    logic                     rst;
    logic                     instr_valid;
    vec_isa_pkg::instr_u      instr;
    vec_pipe_pkg::vec_t       vec_a;
    vec_pipe_pkg::vec_t       vec_b;
    logic [`VEC_WIDTH-1:0]    scalar;
    logic                     busy;
    logic                     write_valid;
    vec_pipe_pkg::mem_write_t write;
    logic                     done;

    record_t records[$];
    bit      loaded = 1'b0;
    int      tb_errors = 0;
    int      total_errors;

    vec_unit_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .vec_a       (vec_a),
        .vec_b       (vec_b),
        .scalar      (scalar),
        .busy        (busy),
        .write_valid (write_valid),
        .write       (write),
        .done        (done)
    );

    // Write port monitor and scoreboard
    vec_unit_checker chk0 (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .busy        (busy),
        .write_valid (write_valid),
        .write       (write),
        .done        (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Scalar rule: operand combined with sign-extended immediate
    function automatic logic [`VEC_WIDTH-1:0] scalar_result(vec_isa_pkg::opcode_e op,
            logic [`VEC_WIDTH-1:0] s, logic [15:0] imm);
        logic [`VEC_WIDTH-1:0] ext;
        ext = $signed(imm);
        case (op)
            vec_isa_pkg::SADD: return s + ext;
            vec_isa_pkg::SSUB: return s - ext;
            vec_isa_pkg::SAND: return s & ext;
            vec_isa_pkg::SXOR: return s ^ ext;
            default:           return '0;
        endcase
    endfunction

    // Vector rule for one element
    function automatic logic [`VEC_WIDTH-1:0] elem_result(vec_isa_pkg::opcode_e op,
            logic [`VEC_WIDTH-1:0] a, logic [`VEC_WIDTH-1:0] b, logic [`VEC_WIDTH-1:0] s);
        logic [2*`VEC_WIDTH-1:0] full;
        case (op)
            vec_isa_pkg::VADD:   full = a + b;
            vec_isa_pkg::VSUB:   full = a - b;
            vec_isa_pkg::VMUL:   full = a * b;
            vec_isa_pkg::VSCALE: full = a * s;
            default:             full = '0;
        endcase
        // Keep only the element width
        return full[`VEC_WIDTH-1:0];
    endfunction

    task automatic load_records();
        int          fd;
        int          n;
        string       line;
        logic [31:0] w;
        logic [31:0] s;
        logic [31:0] t;
        logic [31:0] d;
        fd = $fopen("sim/vec_unit_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file sim/vec_unit_input.txt");
            tb_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Skip comments
                if (line.len() > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h", w, s, t, d);
                    if (n == 4) begin
                        records.push_back('{w, s, t[3:0], d[0]});
                    end else if (n > 0) begin
                        $display("Malformed stimulus line: %s", line);
                        tb_errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic fill_operands(input logic [3:0] tag, output vec_pipe_pkg::vec_t a,
                                 output vec_pipe_pkg::vec_t b);
        for (int i = 0; i < `VEC_ITEMS; i++) begin
            case (tag)
                // Small values
                4'd1: begin
                    a[i] = $urandom_range(255);
                    b[i] = $urandom_range(255);
                end
                // B all ones
                4'd2: begin
                    a[i] = $urandom;
                    b[i] = '1;
                end
                default: begin
                    a[i] = $urandom;
                    b[i] = $urandom;
                end
            endcase
        end
    endtask

    task automatic queue_expected(input record_t r, input vec_pipe_pkg::vec_t a,
                                  input vec_pipe_pkg::vec_t b);
        logic [3:0]               op_bits;
        vec_pipe_pkg::mem_write_t w;
        op_bits = r.instr.scalar.op;
        if (op_bits[vec_isa_pkg::OP_WIDTH-1]) begin
            for (int i = 0; i < `VEC_ITEMS; i++) begin
                // Base plus index, modulo the address space
                w.addr = (int'(r.instr.vector.addr) + i) % (1 << `VEC_ADDR_WIDTH);
                w.data = elem_result(r.instr.vector.op, a[i], b[i], r.scalar);
                chk0.expect_write(w, i == 0, i == `VEC_ITEMS - 1);
            end
        end else begin
            w.addr = r.instr.scalar.addr;
            w.data = scalar_result(r.instr.scalar.op, r.scalar, r.instr.scalar.imm);
            chk0.expect_write(w, 1'b1, 1'b1);
        end
    endtask

    // Busy read mid-cycle, stable until the next edge
    task automatic wait_idle();
        @(negedge clk);
        while (busy) @(negedge clk);
    endtask

    task automatic drive_strobe(input record_t r, input vec_pipe_pkg::vec_t a,
                                input vec_pipe_pkg::vec_t b);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= r.instr;
        vec_a       <= a;
        vec_b       <= b;
        scalar      <= r.scalar;
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    task automatic run_record(input record_t r);
        vec_pipe_pkg::vec_t a;
        vec_pipe_pkg::vec_t b;
        fill_operands(r.tag, a, b);
        if (r.drop) begin
            // Strobe into the busy window of the previous instruction
            @(negedge clk);
            if (!busy) begin
                $display("Busy was low where a strobe should have been dropped");
                tb_errors++;
            end
            drive_strobe(r, a, b);
        end else begin
            wait_idle();
            queue_expected(r, a, b);
            drive_strobe(r, a, b);
        end
    endtask

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        vec_a       = '0;
        vec_b       = '0;
        scalar      = '0;
        void'($urandom(97188));
        load_records();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        if (records.size() == 0) begin
            $display("No stimulus records were read");
            tb_errors++;
        end else begin
            // Idle gap to observe post-reset outputs
            repeat (3) @(posedge clk);
            foreach (records[i]) begin
                run_record(records[i]);
            end
            wait_idle();
            repeat (3) @(posedge clk);
            chk0.report_missing();
        end
        total_errors = chk0.errors + tb_errors + dut0.u_write_stage.props0.fails;
        $display("Errors: checker %0d, testbench %0d, assertions %0d",
                 chk0.errors, tb_errors, dut0.u_write_stage.props0.fails);
        if (total_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Budget per record covers a full vector burst plus issue overhead
    initial begin
        wait (loaded);
        #((records.size() * (`VEC_ITEMS + 10) + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("Timeout: the run did not finish within its time budget");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- sim/vec_unit_checker.sv
`timescale 1ns/10ps

`include "vec_settings.svh"

module vec_unit_checker (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      instr_valid,
    input  logic                      busy,
    input  logic                      write_valid,
    input  vec_pipe_pkg::mem_write_t  write,
    input  logic                      done
);

    // Expected write with its position in the burst
    typedef struct packed {
        vec_pipe_pkg::mem_write_t wr;
        logic                     first;
        logic                     last;
    } exp_write_t;

    exp_write_t      expected[$];
    longint unsigned accept_cycles[$];
    longint unsigned cycle = 0;
    longint unsigned prev_write_cycle = 0;
    bit              seen_accept = 1'b0;
    int              errors = 0;

    task automatic expect_write(input vec_pipe_pkg::mem_write_t wr, input logic first,
                                input logic last);
        expected.push_back('{wr, first, last});
    endtask

    task automatic report_missing();
        if (expected.size() != 0) begin
            errors++;
            $display("Missing writes: %0d expected writes never appeared, first at address %h",
                     expected.size(), expected[0].wr.addr);
        end
    endtask

    always @(posedge clk) begin
        exp_write_t      e;
        longint unsigned acc;
        cycle++;
        if (!rst) begin
            // Outputs quiet until the first accepted instruction
            if (!seen_accept && (busy || write_valid || done)) begin
                errors++;
                $display("Outputs active before any instruction: busy %b write_valid %b done %b",
                         busy, write_valid, done);
            end
            // Same acceptance rule as decode
            if (instr_valid && !busy) begin
                seen_accept = 1'b1;
                accept_cycles.push_back(cycle);
            end
            if (write_valid && expected.size() == 0) begin
                errors++;
                $display("Extra write with nothing expected: address %h data %h",
                         write.addr, write.data);
            end else if (write_valid) begin
                e = expected.pop_front();
                if (write.addr !== e.wr.addr) begin
                    errors++;
                    $display("CHECK FAILED write.addr expected %h got %h", e.wr.addr, write.addr);
                end
                if (write.data !== e.wr.data) begin
                    errors++;
                    $display("CHECK FAILED write.data expected %h got %h", e.wr.data, write.data);
                end
                if (done !== e.last) begin
                    errors++;
                    $display("CHECK FAILED done expected %h got %h", e.last, done);
                end
                // First write three cycles after acceptance
                if (e.first && accept_cycles.size() == 0) begin
                    errors++;
                    $display("First write of a burst without an accepted instruction");
                end else if (e.first) begin
                    acc = accept_cycles.pop_front();
                    if (cycle - acc != 3) begin
                        errors++;
                        $display("CHECK FAILED write_valid latency expected %h got %h",
                                 3, cycle - acc);
                    end
                end else if (cycle != prev_write_cycle + 1) begin
                    errors++;
                    $display("Vector writes were not on consecutive cycles");
                end
                prev_write_cycle = cycle;
            end else if (done) begin
                errors++;
                $display("CHECK FAILED done expected %h got %h", 1'b0, done);
            end
        end
    end

endmodule

//--- sim/vec_unit_props.sv
`timescale 1ns/10ps

`include "vec_settings.svh"

module vec_unit_props (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      busy,
    input  logic                      write_valid,
    input  vec_pipe_pkg::mem_write_t  write,
    input  logic                      done
);

    int unsigned fails = 0;

    // Done closes a burst within one vector length
    done_in_burst: assert property (@(posedge clk) disable iff (rst)
        $rose(write_valid) |-> ##[0:(`VEC_ITEMS-1)] done)
        else begin
            fails++;
            $error("no done within %0d cycles of the first write", `VEC_ITEMS);
        end

    // Burst continues at the next address
    addr_step: assert property (@(posedge clk) disable iff (rst)
        (write_valid && !done) |=>
            (write_valid && write.addr == `VEC_ADDR_WIDTH'($past(write.addr) + 1)))
        else begin
            fails++;
            $error("vector write address did not step by one");
        end

    // Nothing left in flight once done is seen
    busy_after_done: assert property (@(posedge clk) disable iff (rst)
        done |=> !busy)
        else begin
            fails++;
            $error("busy still high the cycle after done");
        end

endmodule

bind vec_write_stage vec_unit_props props0 (
    .clk         (clk),
    .rst         (rst),
    .busy        (busy),
    .write_valid (write_valid),
    .write       (write),
    .done        (done)
);

//--- src/vec_unit_top.sv
`timescale 1ns/10ps

`include "vec_settings.svh"

module vec_unit_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      instr_valid,
    input  vec_isa_pkg::instr_u       instr,
    input  vec_pipe_pkg::vec_t        vec_a,
    input  vec_pipe_pkg::vec_t        vec_b,
    input  logic [`VEC_WIDTH-1:0]     scalar,
    output logic                      busy,
    output logic                      write_valid,
    output vec_pipe_pkg::mem_write_t  write,
    output logic                      done
);

    logic                   dec_valid;
    vec_pipe_pkg::decoded_t dec;
    logic                   res_valid;
    vec_pipe_pkg::result_t  res;
    logic                   wr_busy;

    // Busy from the write stage, plus the decode slot
    // Holds off a second strobe right after acceptance
    assign busy = wr_busy || dec_valid;

    // Instruction register and field split
    vec_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .vec_a       (vec_a),
        .vec_b       (vec_b),
        .scalar      (scalar),
        .busy        (busy),
        .dec_valid   (dec_valid),
        .dec         (dec)
    );

    // ALU stage
    vec_execute u_execute (
        .clk       (clk),
        .rst       (rst),
        .dec_valid (dec_valid),
        .dec       (dec),
        .res_valid (res_valid),
        .res       (res)
    );

    // Memory write sequencer
    vec_write_stage u_write_stage (
        .clk         (clk),
        .rst         (rst),
        .res_valid   (res_valid),
        .res         (res),
        .busy        (wr_busy),
        .write_valid (write_valid),
        .write       (write),
        .done        (done)
    );

endmodule

//--- src/vec_write_stage.sv
`timescale 1ns/10ps

`include "vec_settings.svh"

module vec_write_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      res_valid,
    input  vec_pipe_pkg::result_t     res,
    output logic                      busy,
    output logic                      write_valid,
    output vec_pipe_pkg::mem_write_t  write,
    output logic                      done
);

    // Counter wide enough for every element index
    localparam int CNT_WIDTH = $clog2(`VEC_ITEMS);

    vec_pipe_pkg::result_t      hold;
    logic                       active;
    logic [CNT_WIDTH-1:0]       cnt;
    logic                       last;
    logic [`VEC_WIDTH-1:0]      v_item;
    logic [`VEC_ADDR_WIDTH-1:0] v_addr;

    // Result held for the whole write burst
    always_ff @(posedge clk) begin
        if (res_valid) begin
            hold <= res;
        end
    end

    // Element counter and burst flag
    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (res_valid) begin
            active <= 1'b1;
            cnt    <= '0;
        end else if (active) begin
            if (last) begin
                active <= 1'b0;
                cnt    <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Scalar ends after one write
    assign last = !hold.is_vec || (cnt == CNT_WIDTH'(`VEC_ITEMS - 1));

    // Element pick by counter
    assign v_item = hold.vec[cnt];

    // Base plus index, wraps at address width
    assign v_addr = hold.addr + `VEC_ADDR_WIDTH'(cnt);

    // Scalar or vector path
    assign write.data = hold.is_vec ? v_item : hold.scalar;
    assign write.addr = hold.is_vec ? v_addr : hold.addr;

    // One write per active cycle
    assign write_valid = active;

    // Finished strobe on the last write
    assign done = active && last;

    // Covers the cycle before the burst and the burst itself
    // Decode side is added at the top
    assign busy = res_valid || active;

endmodule

//--- src/vec_execute.sv
`timescale 1ns/10ps

`include "vec_settings.svh"

module vec_execute (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dec_valid,
    input  vec_pipe_pkg::decoded_t  dec,
    output logic                    res_valid,
    output vec_pipe_pkg::result_t   res
);

    logic [`VEC_WIDTH-1:0] imm_ext;
    vec_pipe_pkg::result_t res_next;

    // Sign extend the immediate to element width
    assign imm_ext = {{(`VEC_WIDTH-vec_isa_pkg::IMM_WIDTH){dec.imm[vec_isa_pkg::IMM_WIDTH-1]}},
                      dec.imm};

    always_comb begin
        res_next        = '0;
        res_next.is_vec = dec.is_vec;
        res_next.addr   = dec.addr;
        case (dec.op)
            // Scalar ops against the immediate
            vec_isa_pkg::SADD: res_next.scalar = dec.scalar + imm_ext;
            vec_isa_pkg::SSUB: res_next.scalar = dec.scalar - imm_ext;
            vec_isa_pkg::SAND: res_next.scalar = dec.scalar & imm_ext;
            vec_isa_pkg::SXOR: res_next.scalar = dec.scalar ^ imm_ext;
            // Element-wise A op B
            vec_isa_pkg::VADD: begin
                for (int i = 0; i < `VEC_ITEMS; i++) begin
                    res_next.vec[i] = dec.vec_a[i] + dec.vec_b[i];
                end
            end
            vec_isa_pkg::VSUB: begin
                for (int i = 0; i < `VEC_ITEMS; i++) begin
                    res_next.vec[i] = dec.vec_a[i] - dec.vec_b[i];
                end
            end
            // Products keep the low element bits
            vec_isa_pkg::VMUL: begin
                for (int i = 0; i < `VEC_ITEMS; i++) begin
                    res_next.vec[i] = dec.vec_a[i] * dec.vec_b[i];
                end
            end
            // A times the scalar operand
            vec_isa_pkg::VSCALE: begin
                for (int i = 0; i < `VEC_ITEMS; i++) begin
                    res_next.vec[i] = dec.vec_a[i] * dec.scalar;
                end
            end
            // Unassigned opcodes give zero
            default: begin
                res_next.scalar = '0;
            end
        endcase
    end

    // Valid strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= dec_valid;
        end
    end

    // Result register
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            res <= res_next;
        end
    end

endmodule

//--- src/vec_decode.sv
`timescale 1ns/10ps

`include "vec_settings.svh"

module vec_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  vec_isa_pkg::instr_u     instr,
    input  vec_pipe_pkg::vec_t      vec_a,
    input  vec_pipe_pkg::vec_t      vec_b,
    input  logic [`VEC_WIDTH-1:0]   scalar,
    input  logic                    busy,
    output logic                    dec_valid,
    output vec_pipe_pkg::decoded_t  dec
);

    logic                   accept;
    logic                   is_vec;
    vec_pipe_pkg::decoded_t dec_next;

    // Strobes during busy are dropped
    assign accept = instr_valid && !busy;

    // Opcode sits at the same place in both formats
    assign is_vec = vec_isa_pkg::is_vector_op(instr.scalar.op);

    always_comb begin
        dec_next        = '0;
        dec_next.op     = instr.scalar.op;
        dec_next.is_vec = is_vec;
        // Read fields through the matching format
        if (is_vec) begin
            dec_next.addr = instr.vector.addr;
            // No immediate in vector format
            dec_next.imm  = '0;
        end else begin
            dec_next.addr = instr.scalar.addr;
            dec_next.imm  = instr.scalar.imm;
        end
        // Operands taken with the strobe
        dec_next.vec_a  = vec_a;
        dec_next.vec_b  = vec_b;
        dec_next.scalar = scalar;
    end

    // Valid strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= accept;
        end
    end

    // Decoded record, loaded only on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            dec <= dec_next;
        end
    end

endmodule

//--- src/vec_pipe_pkg.sv
`include "vec_settings.svh"

package vec_pipe_pkg;

    // One full vector operand or result
    typedef logic [`VEC_ITEMS-1:0][`VEC_WIDTH-1:0] vec_t;

    // Decode to execute
    // Operands latched with the instruction
    typedef struct packed {
        vec_isa_pkg::opcode_e                     op;
        logic                                     is_vec;
        logic [vec_isa_pkg::IMM_WIDTH-1:0]        imm;
        logic [`VEC_ADDR_WIDTH-1:0]               addr;
        vec_t                                     vec_a;
        vec_t                                     vec_b;
        logic [`VEC_WIDTH-1:0]                    scalar;
    } decoded_t;

    // Execute to write stage
    typedef struct packed {
        logic                        is_vec;
        vec_t                        vec;
        logic [`VEC_WIDTH-1:0]       scalar;
        logic [`VEC_ADDR_WIDTH-1:0]  addr;
    } result_t;

    // One data memory write
    typedef struct packed {
        logic [`VEC_ADDR_WIDTH-1:0]  addr;
        logic [`VEC_WIDTH-1:0]       data;
    } mem_write_t;

endpackage

//--- src/vec_isa_pkg.sv
`include "vec_settings.svh"

package vec_isa_pkg;

    // Field widths fixed by the encoding
    localparam int OP_WIDTH  = 4;
    localparam int IMM_WIDTH = 16;

    // Top opcode bit set means vector class
    typedef enum logic [OP_WIDTH-1:0] {
        SADD   = 4'h0,
        SSUB   = 4'h1,
        SAND   = 4'h2,
        SXOR   = 4'h3,
        VADD   = 4'h8,
        VSUB   = 4'h9,
        VMUL   = 4'hA,
        VSCALE = 4'hB
    } opcode_e;

    // Scalar format: opcode, immediate, spare bits, target address
    typedef struct packed {
        opcode_e                     op;
        logic [IMM_WIDTH-1:0]        imm;
        logic [`VEC_INSTR_WIDTH-OP_WIDTH-IMM_WIDTH-`VEC_ADDR_WIDTH-1:0] rsvd;
        logic [`VEC_ADDR_WIDTH-1:0]  addr;
    } scalar_instr_t;

    // Vector format: opcode, spare bits, base address
    typedef struct packed {
        opcode_e                     op;
        logic [`VEC_INSTR_WIDTH-OP_WIDTH-`VEC_ADDR_WIDTH-1:0] rsvd;
        logic [`VEC_ADDR_WIDTH-1:0]  addr;
    } vector_instr_t;

    // Same word, read per opcode class
    typedef union packed {
        scalar_instr_t scalar;
        vector_instr_t vector;
    } instr_u;

    // Class bit of an opcode
    function automatic logic is_vector_op(opcode_e op);
        return op[OP_WIDTH-1];
    endfunction

endpackage

//--- src/vec_settings.svh
`ifndef VEC_SETTINGS_SVH
`define VEC_SETTINGS_SVH

// Sizes shared by the packages and the RTL

// Elements per vector
`define VEC_ITEMS 20

// Element and scalar width in bits
`define VEC_WIDTH 32

// Data memory address width
// Vector addresses wrap at this width
`define VEC_ADDR_WIDTH 10

// Instruction word width
// Must leave room for opcode, immediate and address
`define VEC_INSTR_WIDTH 32

`endif
